// File: logic/mem_map_consts.svh
// memory map constants
// bank geometry, address widths, queue depth and section limits
// shared by the packages and the RTL of the mapping subsystem

`ifndef MEM_MAP_CONSTS_SVH
`define MEM_MAP_CONSTS_SVH

////////////////////////////////////////////////////////////
// bank geometry
////////////////////////////////////////////////////////////

// banks per memory and the index width
`define MM_NB_BANKS   4
`define MM_BANK_SEL_W 2

// word offset inside one memory (4096 words)
`define MM_WOFF_W     12
// rows per bank (1024)
`define MM_ROW_W      10

////////////////////////////////////////////////////////////
// configuration and queueing
////////////////////////////////////////////////////////////

// largest accepted sequential-section size (log2 of words per bank)
`define MM_SEQSEC_MAX 10
`define MM_FIFO_DEPTH 4
// transaction id on the peripheral bus
`define MM_ID_W       5

`endif

// File: logic/periph_bus_pkg.sv
// peripheral bus types
// request and response structs of the cluster peripheral bus
// the grant is implied, so only the strobe and response travel here

`include "mem_map_consts.svh"

package periph_bus_pkg;

  ////////////////////////////////////////////////////////////
  // common fields
  ////////////////////////////////////////////////////////////

  // transaction id echoed back in the response
  typedef logic [`MM_ID_W-1:0] periph_id_t;

  ////////////////////////////////////////////////////////////
  // request and response
  ////////////////////////////////////////////////////////////

  // master to slave, req is a one-cycle strobe
  typedef struct packed {
    logic        req;
    // low means write
    logic        wen;
    logic [31:0] add;
    logic [31:0] wdata;
    logic [3:0]  be;
    periph_id_t  id;
  } periph_req_t;

  // slave to master, r_valid pulses one cycle after req
  typedef struct packed {
    logic        r_valid;
    logic [31:0] r_rdata;
    periph_id_t  r_id;
  } periph_rsp_t;

endpackage

// File: logic/mem_map_pkg.sv
// memory map types
// section configuration, core request and bank request structs
// used between the config unit, the request queue and the mapper

`include "mem_map_consts.svh"

package mem_map_pkg;

  ////////////////////////////////////////////////////////////
  // configuration
  ////////////////////////////////////////////////////////////

  // log2 of the sequential words per bank, zero means no section
  typedef struct packed {
    logic [3:0] sram_size;
    logic [3:0] scm_size;
  } seqsec_cfg_t;

  ////////////////////////////////////////////////////////////
  // requests
  ////////////////////////////////////////////////////////////

  // core side request as pushed into the queue
  typedef struct packed {
    // byte address, bit 14 picks the memory
    logic [15:0] addr;
    logic [7:0]  tag;
  } core_req_t;

  // memory select for the bank request
  typedef enum logic {
    REGION_SRAM = 1'b0,
    REGION_SCM  = 1'b1
  } region_e;

  // bank side request after mapping
  typedef struct packed {
    region_e                   region;
    logic [`MM_BANK_SEL_W-1:0] bank;
    logic [`MM_ROW_W-1:0]      row;
    logic [7:0]                tag;
  } bank_req_t;

endpackage

// File: logic/seqsec_config_unit.sv
// sequential-section config unit
// peripheral bus slave with two size registers, one for the SRAM
// and one for the SCM, answering each request one cycle later
// written sizes are clamped and driven out continuously

`include "mem_map_consts.svh"

module seqsec_config_unit (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  periph_bus_pkg::periph_req_t bus_req,
  output periph_bus_pkg::periph_rsp_t bus_rsp,
  output mem_map_pkg::seqsec_cfg_t    cfg
);

  import periph_bus_pkg::*;
  import mem_map_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WR_RSP,
    ST_RD_RSP
  } state_e;

  state_e      state_q, state_d;
  periph_id_t  id_q;
  // register select, 0 is SRAM and 1 is SCM
  logic        sel_q;
  seqsec_cfg_t sizes_q;
  periph_rsp_t rsp_d;
  logic        accept;
  logic        do_write;
  logic [3:0]  wr_val;

  ////////////////////////////////////////////////////////////
  // request decode
  ////////////////////////////////////////////////////////////

  // only an idle slave takes a request
  assign accept   = (state_q == ST_IDLE) && bus_req.req;
  assign do_write = accept && !bus_req.wen && bus_req.be[0];

  // clamp the written size to the supported maximum
  assign wr_val = (bus_req.wdata[3:0] > 4'(`MM_SEQSEC_MAX)) ?
                  4'(`MM_SEQSEC_MAX) : bus_req.wdata[3:0];

  ////////////////////////////////////////////////////////////
  // transfer FSM and response
  ////////////////////////////////////////////////////////////

  always_comb begin
    rsp_d   = '0;
    state_d = ST_IDLE;
    case (state_q)
      ST_IDLE: begin
        if (bus_req.req) begin
          state_d = bus_req.wen ? ST_RD_RSP : ST_WR_RSP;
        end
      end
      // write response carries no data
      ST_WR_RSP: begin
        rsp_d.r_valid = 1'b1;
        rsp_d.r_id    = id_q;
      end
      // read returns the selected size zero-extended
      ST_RD_RSP: begin
        rsp_d.r_valid = 1'b1;
        rsp_d.r_id    = id_q;
        rsp_d.r_rdata = {28'b0, sel_q ? sizes_q.scm_size : sizes_q.sram_size};
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
      id_q    <= '0;
      sel_q   <= 1'b0;
      sizes_q <= '0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        id_q  <= bus_req.id;
        sel_q <= bus_req.add[2];
      end
      // size lands now so it is visible on the response cycle
      if (do_write) begin
        if (bus_req.add[2]) sizes_q.scm_size <= wr_val;
        else                sizes_q.sram_size <= wr_val;
      end
    end
  end

  assign bus_rsp = rsp_d;
  assign cfg     = sizes_q;

endmodule

// File: logic/req_fifo.sv
// request queue
// small circular buffer for core requests, payload set by type
// a push into a full queue without a pop is dropped and flagged

`include "mem_map_consts.svh"

module req_fifo #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     push,
  input  payload_t push_data,
  input  logic     pop,
  output payload_t head,
  output logic     empty,
  output logic     overflow
);

  localparam int unsigned DEPTH = `MM_FIFO_DEPTH;
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  payload_t             mem_q [DEPTH];
  logic     [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic     [CNT_W-1:0] count_q;
  logic                 full;
  logic                 do_push, do_pop;

  ////////////////////////////////////////////////////////////
  // flags and handshake
  ////////////////////////////////////////////////////////////

  assign empty = (count_q == '0);
  assign full  = (count_q == CNT_W'(DEPTH));

  // a pop frees the slot so a full queue still takes the push
  assign do_pop  = pop && !empty;
  assign do_push = push && (!full || do_pop);

  assign head = mem_q[rd_ptr_q];

  ////////////////////////////////////////////////////////////
  // storage and pointers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (do_push) mem_q[wr_ptr_q] <= push_data;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      overflow <= 1'b0;
    end else begin
      if (do_push) wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      if (do_pop)  rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      if (do_push && !do_pop)      count_q <= count_q + 1'b1;
      else if (do_pop && !do_push) count_q <= count_q - 1'b1;
      // sticky until reset
      if (push && !do_push) overflow <= 1'b1;
    end
  end

endmodule

// File: logic/bank_addr_mapper.sv
// bank address mapper
// takes the queue head and maps its address to region, bank and row
// the low part of each memory is sequential per bank, the rest is
// word interleaved across the banks, output is held while stalled

`include "mem_map_consts.svh"

module bank_addr_mapper (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  mem_map_pkg::seqsec_cfg_t cfg,
  input  mem_map_pkg::core_req_t   head,
  input  logic                     empty,
  output logic                     pop,
  input  logic                     stall,
  output logic                     bank_valid,
  output mem_map_pkg::bank_req_t   bank_req
);

  import mem_map_pkg::*;

  // one extra bit so the bound can reach the full memory
  localparam int unsigned SPAN_W = `MM_WOFF_W + 1;

  logic [`MM_WOFF_W-1:0] word_off;
  logic [`MM_WOFF_W-1:0] ilv_off;
  logic [3:0]            sec_size;
  logic [SPAN_W-1:0]     sec_words;
  logic [SPAN_W-1:0]     sec_bound;
  logic                  in_seq;
  bank_req_t             map_d;

  ////////////////////////////////////////////////////////////
  // address mapping
  ////////////////////////////////////////////////////////////

  assign word_off = head.addr[13:2];
  assign map_d.region = region_e'(head.addr[14]);
  assign sec_size = head.addr[14] ? cfg.scm_size : cfg.sram_size;

  // words per bank in the section and the whole section span
  assign sec_words = (sec_size == 4'd0) ? '0 : (SPAN_W'(1) << sec_size);
  assign sec_bound = sec_words * SPAN_W'(`MM_NB_BANKS);
  assign in_seq    = ({1'b0, word_off} < sec_bound);

  // offset into the interleaved part
  assign ilv_off = word_off - sec_bound[`MM_WOFF_W-1:0];

  assign map_d.bank = in_seq ? `MM_BANK_SEL_W'(word_off >> sec_size) :
                               ilv_off[`MM_BANK_SEL_W-1:0];
  // interleaved rows start right after the sequential rows
  assign map_d.row = in_seq ?
      `MM_ROW_W'({1'b0, word_off} & (sec_words - 1'b1)) :
      `MM_ROW_W'(sec_words + SPAN_W'(ilv_off >> `MM_BANK_SEL_W));
  assign map_d.tag = head.tag;

  ////////////////////////////////////////////////////////////
  // output register
  ////////////////////////////////////////////////////////////

  // take the head when the slot is empty or its item leaves now
  assign pop = !empty && (!bank_valid || !stall);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bank_valid <= 1'b0;
    end else if (!bank_valid || !stall) begin
      bank_valid <= !empty;
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop) bank_req <= map_d;
  end

endmodule

// File: logic/mem_map_top.sv
// memory map top level
// config unit on the peripheral bus, request queue on the core side
// and the bank address mapper feeding the bank side

module mem_map_top (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  periph_bus_pkg::periph_req_t bus_req,
  output periph_bus_pkg::periph_rsp_t bus_rsp,
  input  logic                        push,
  input  mem_map_pkg::core_req_t      core_req,
  output logic                        overflow,
  input  logic                        stall,
  output logic                        bank_valid,
  output mem_map_pkg::bank_req_t      bank_req
);

  import mem_map_pkg::*;

  seqsec_cfg_t cfg;
  core_req_t   fifo_head;
  logic        fifo_empty;
  logic        fifo_pop;

  // section sizes from the peripheral bus
  seqsec_config_unit i_cfg (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .bus_req (bus_req),
    .bus_rsp (bus_rsp),
    .cfg     (cfg)
  );

  // core requests wait here until the mapper takes them
  req_fifo #(
    .payload_t (core_req_t)
  ) i_fifo (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .push      (push),
    .push_data (core_req),
    .pop       (fifo_pop),
    .head      (fifo_head),
    .empty     (fifo_empty),
    .overflow  (overflow)
  );

  bank_addr_mapper i_mapper (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .cfg        (cfg),
    .head       (fifo_head),
    .empty      (fifo_empty),
    .pop        (fifo_pop),
    .stall      (stall),
    .bank_valid (bank_valid),
    .bank_req   (bank_req)
  );

endmodule

// File: dv/mem_map_assert.sv
// protocol assertions for the memory map top level
// bus response timing, bank request hold under stall, sticky overflow

module mem_map_assert (
  input logic                        clk_i,
  input logic                        rst_ni,
  input periph_bus_pkg::periph_req_t bus_req,
  input periph_bus_pkg::periph_rsp_t bus_rsp,
  input logic                        overflow,
  input logic                        stall,
  input logic                        bank_valid,
  input mem_map_pkg::bank_req_t      bank_req
);
  timeunit 1ns;
  timeprecision 1ps;

  int unsigned fail_cnt = 0;

  // an idle slave answers exactly one cycle after the strobe
  rsp_after_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
      bus_req.req && !bus_rsp.r_valid |=> bus_rsp.r_valid)
    else begin
      $error("r_valid did not follow req");
      fail_cnt++;
    end

  rsp_has_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
      bus_rsp.r_valid |-> $past(bus_req.req))
    else begin
      $error("r_valid without a request one cycle before");
      fail_cnt++;
    end

  // master leaves the response cycle idle
  no_req_on_rsp: assert property (@(posedge clk_i) disable iff (!rst_ni)
      bus_rsp.r_valid |-> !bus_req.req)
    else begin
      $error("request on a response cycle");
      fail_cnt++;
    end

  bank_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
      bank_valid && stall |=> bank_valid && $stable(bank_req))
    else begin
      $error("bank request changed under stall");
      fail_cnt++;
    end

  ovf_sticky: assert property (@(posedge clk_i) disable iff (!rst_ni)
      overflow |=> overflow)
    else begin
      $error("overflow fell before reset");
      fail_cnt++;
    end

endmodule

bind mem_map_top mem_map_assert u_assert (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .bus_req    (bus_req),
  .bus_rsp    (bus_rsp),
  .overflow   (overflow),
  .stall      (stall),
  .bank_valid (bank_valid),
  .bank_req   (bank_req)
);

// File: dv/mem_map_checker.sv
// memory map scoreboard
// models the size registers, queue occupancy and mapper slot from the
// port behaviour, then compares bus responses and bank requests

`include "mem_map_consts.svh"

module mem_map_checker (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  periph_bus_pkg::periph_req_t bus_req,
  input  periph_bus_pkg::periph_rsp_t bus_rsp,
  input  logic                        push,
  input  mem_map_pkg::core_req_t      core_req,
  input  logic                        overflow,
  input  logic                        stall,
  input  logic                        bank_valid,
  input  mem_map_pkg::bank_req_t      bank_req,
  input  logic [31:0]                 exp_rdata,
  output logic                        drained
);
  timeunit 1ns;
  timeprecision 1ps;

  import periph_bus_pkg::*;
  import mem_map_pkg::*;

  int unsigned         err_cnt   = 0;
  logic [3:0]          sram_sz   = '0;
  logic [3:0]          scm_sz    = '0;
  core_req_t           fifo_q[$];
  bank_req_t           slot      = '0;
  logic                slot_full = 1'b0;
  logic                ovf_exp   = 1'b0;
  logic                rsp_due   = 1'b0;
  logic [31:0]         rsp_data  = '0;
  logic [`MM_ID_W-1:0] rsp_id    = '0;

  // sequential low part per bank, interleaved remainder
  function automatic bank_req_t map_addr(core_req_t r, logic [3:0] sram, logic [3:0] scm);
    int unsigned w;
    int unsigned s;
    int unsigned n;
    bank_req_t   b;
    w = 32'(r.addr[13:2]);
    s = 32'(r.addr[14] ? scm : sram);
    n = (s == 0) ? 0 : (1 << s);
    b.region = region_e'(r.addr[14]);
    b.tag    = r.tag;
    if (w < 4 * n) begin
      b.bank = 2'(w >> s);
      b.row  = 10'(w % n);
    end else begin
      b.bank = 2'((w - 4 * n) % 4);
      b.row  = 10'(n + (w - 4 * n) / 4);
    end
    return b;
  endfunction

  always @(posedge clk_i or negedge rst_ni) begin
    logic [3:0] wval;
    if (!rst_ni) begin
      sram_sz   = '0;
      scm_sz    = '0;
      slot_full = 1'b0;
      ovf_exp   = 1'b0;
      rsp_due   = 1'b0;
      fifo_q.delete();
      drained <= 1'b1;
    end else begin
      // bank side against the state before this edge
      if (bank_valid !== slot_full) begin
        err_cnt++;
        if (slot_full) $display("bank_valid missing while tag %h is expected", slot.tag);
        else $display("unexpected bank_valid with tag %h", bank_req.tag);
      end else if (slot_full && !stall && bank_req !== slot) begin
        err_cnt++;
        $display("MISMATCH bank_req: got %h expected %h", bank_req, slot);
      end
      if (overflow !== ovf_exp) begin
        err_cnt++;
        $display("MISMATCH overflow: got %h expected %h", overflow, ovf_exp);
      end
      // slot refills from the head, sizes as they stand before this edge
      if (fifo_q.size() > 0 && (!slot_full || !stall)) begin
        slot      = map_addr(fifo_q.pop_front(), sram_sz, scm_sz);
        slot_full = 1'b1;
      end else if (!stall) begin
        slot_full = 1'b0;
      end
      // a push after the pop, full queue drops it
      if (push) begin
        if (fifo_q.size() < `MM_FIFO_DEPTH) fifo_q.push_back(core_req);
        else ovf_exp = 1'b1;
      end
      // peripheral bus response
      if (rsp_due) begin
        if (!bus_rsp.r_valid) begin
          err_cnt++;
          $display("bus response missing for id %h", rsp_id);
        end else if (bus_rsp.r_id !== rsp_id) begin
          err_cnt++;
          $display("MISMATCH r_id: got %h expected %h", bus_rsp.r_id, rsp_id);
        end else if (bus_rsp.r_rdata !== rsp_data) begin
          err_cnt++;
          $display("MISMATCH r_rdata: got %h expected %h", bus_rsp.r_rdata, rsp_data);
        end
      end else if (bus_rsp.r_valid) begin
        err_cnt++;
        $display("unexpected bus response with id %h", bus_rsp.r_id);
      end
      if (bus_req.req && !rsp_due) begin
        rsp_due  = 1'b1;
        rsp_id   = bus_req.id;
        rsp_data = exp_rdata;
        // byte 0 enables the write, value clamped
        if (!bus_req.wen && bus_req.be[0]) begin
          wval = bus_req.wdata[3:0];
          if (wval > 4'(`MM_SEQSEC_MAX)) wval = 4'(`MM_SEQSEC_MAX);
          if (bus_req.add[2]) scm_sz = wval;
          else sram_sz = wval;
        end
      end else begin
        rsp_due = 1'b0;
      end
      drained <= (fifo_q.size() == 0) && !slot_full;
    end
  end

endmodule

// File: dv/mem_map_tb.sv
// memory map testbench
// clock, reset and a stimulus table of bus operations and core pushes
// each entry carries its stall pattern and the checker does all comparing

module mem_map_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import periph_bus_pkg::*;
  import mem_map_pkg::*;

  typedef enum logic [1:0] {OP_WR, OP_RD, OP_PUSH, OP_PUSH_RND} op_e;
  typedef enum logic [1:0] {ST_LOW, ST_RND, ST_HIGH} stall_e;

  typedef struct packed {
    op_e         op;
    logic [15:0] addr;
    // write data, or the expected read data of a read
    logic [31:0] data;
    logic [3:0]  be;
    stall_e      st;
    logic [5:0]  reps;
  } entry_t;

  localparam int N_ENT = 25;
  // cycle budget for the whole run
  localparam int LIMIT = N_ENT * 20 + 200;

  ////////////////////////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////////////////////////

  localparam entry_t TBL [N_ENT] = '{
    // reset values, then clamped writes and a masked write
    '{OP_RD,       16'h0000, 32'h0, 4'hf, ST_LOW,  6'd1},
    '{OP_RD,       16'h0004, 32'h0, 4'hf, ST_LOW,  6'd1},
    '{OP_WR,       16'h0000, 32'h5, 4'h1, ST_LOW,  6'd1},
    '{OP_RD,       16'h0000, 32'h5, 4'hf, ST_LOW,  6'd1},
    '{OP_WR,       16'h0004, 32'hf, 4'h1, ST_LOW,  6'd1},
    '{OP_RD,       16'h0004, 32'ha, 4'hf, ST_LOW,  6'd1},
    '{OP_WR,       16'h0000, 32'h3, 4'he, ST_LOW,  6'd1},
    '{OP_RD,       16'h0000, 32'h5, 4'hf, ST_LOW,  6'd1},
    '{OP_WR,       16'h0000, 32'h0, 4'hf, ST_LOW,  6'd1},
    '{OP_WR,       16'h0004, 32'h0, 4'hf, ST_LOW,  6'd1},
    '{OP_RD,       16'h0004, 32'h0, 4'hf, ST_LOW,  6'd1},
    // fully interleaved
    '{OP_PUSH_RND, 16'h0000, 32'h0, 4'h0, ST_LOW,  6'd24},
    // sram section of 4 words per bank and scm section of 8
    '{OP_WR,       16'h0000, 32'h2, 4'h1, ST_LOW,  6'd1},
    '{OP_WR,       16'h0004, 32'h3, 4'h1, ST_LOW,  6'd1},
    '{OP_RD,       16'h0000, 32'h2, 4'hf, ST_LOW,  6'd1},
    '{OP_PUSH,     16'h0014, 32'h0, 4'h0, ST_LOW,  6'd1},
    '{OP_PUSH,     16'h003c, 32'h0, 4'h0, ST_LOW,  6'd1},
    '{OP_PUSH,     16'h0054, 32'h0, 4'h0, ST_LOW,  6'd1},
    '{OP_PUSH,     16'h3ffc, 32'h0, 4'h0, ST_LOW,  6'd1},
    '{OP_PUSH,     16'h407c, 32'h0, 4'h0, ST_LOW,  6'd1},
    '{OP_PUSH,     16'h4190, 32'h0, 4'h0, ST_LOW,  6'd1},
    '{OP_PUSH_RND, 16'h0000, 32'h0, 4'h0, ST_LOW,  6'd16},
    // random stall, then a long stall that drops the sixth push
    '{OP_PUSH_RND, 16'h0000, 32'h0, 4'h0, ST_RND,  6'd32},
    '{OP_PUSH_RND, 16'h0000, 32'h0, 4'h0, ST_HIGH, 6'd6},
    '{OP_RD,       16'h0004, 32'h3, 4'hf, ST_LOW,  6'd1}
  };

  logic        clk_i;
  logic        rst_ni;
  periph_req_t bus_req;
  periph_rsp_t bus_rsp;
  logic        push;
  core_req_t   core_req;
  logic        overflow;
  logic        stall;
  logic        bank_valid;
  bank_req_t   bank_req;
  logic [31:0] exp_rdata;
  logic        drained;
  int unsigned cycles = 0;
  logic [7:0]  tag_q;
  logic [4:0]  id_q;

  mem_map_top dut (.*);

  mem_map_checker chk (.*);

  initial clk_i = 1'b0;
  always #4 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles == LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", LIMIT);
      $display("** FAIL **");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // drivers
  ////////////////////////////////////////////////////////////

  function automatic logic stall_level(stall_e st);
    case (st)
      ST_HIGH: return 1'b1;
      ST_RND:  return ($urandom % 2) == 1;
      default: return 1'b0;
    endcase
  endfunction

  // strobe, then the response cycle and one more idle cycle
  task automatic bus_op(entry_t e);
    @(posedge clk_i);
    bus_req.req   <= 1'b1;
    bus_req.wen   <= (e.op == OP_RD);
    bus_req.add   <= {16'h0, e.addr};
    bus_req.wdata <= e.data;
    bus_req.be    <= e.be;
    bus_req.id    <= id_q;
    // a write answers with zero data
    exp_rdata     <= (e.op == OP_RD) ? e.data : 32'h0;
    id_q = id_q + 5'd3;
    @(posedge clk_i);
    bus_req.req <= 1'b0;
    @(posedge clk_i);
  endtask

  // run the stall pattern until every pushed item has left
  task automatic wait_drained(stall_e st);
    do begin
      @(posedge clk_i);
      stall <= stall_level(st);
    end while (!drained);
    stall <= 1'b0;
  endtask

  task automatic push_entry(entry_t e);
    for (int r = 0; r < int'(e.reps); r++) begin
      @(posedge clk_i);
      push          <= 1'b1;
      core_req.addr <= (e.op == OP_PUSH_RND) ? 16'($urandom) : e.addr;
      core_req.tag  <= tag_q;
      stall         <= stall_level(e.st);
      tag_q = tag_q + 8'd1;
      // bursts of four fit queue and mapper under any stall
      if (e.st == ST_RND && r % 4 == 3) begin
        @(posedge clk_i);
        push <= 1'b0;
        wait_drained(ST_RND);
      end
    end
    @(posedge clk_i);
    push <= 1'b0;
    // long stall keeps the queue full
    if (e.st == ST_HIGH) repeat (6) @(posedge clk_i);
    wait_drained((e.st == ST_HIGH) ? ST_LOW : e.st);
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'hd611));
    rst_ni    = 1'b0;
    bus_req   = '0;
    push      = 1'b0;
    core_req  = '0;
    stall     = 1'b0;
    exp_rdata = '0;
    tag_q     = 8'h00;
    id_q      = 5'h01;
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    for (int i = 0; i < N_ENT; i++) begin
      if (TBL[i].op == OP_WR || TBL[i].op == OP_RD) bus_op(TBL[i]);
      else push_entry(TBL[i]);
    end
    repeat (4) @(posedge clk_i);
    // counters settle away from the sampling edge
    @(negedge clk_i);
    $display("checker errors %0d, assertion failures %0d", chk.err_cnt,
             dut.u_assert.fail_cnt);
    if (chk.err_cnt == 0 && dut.u_assert.fail_cnt == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: verilog.f
+incdir+logic
logic/periph_bus_pkg.sv
logic/mem_map_pkg.sv
logic/seqsec_config_unit.sv
logic/req_fifo.sv
logic/bank_addr_mapper.sv
logic/mem_map_top.sv
dv/mem_map_assert.sv
dv/mem_map_checker.sv
dv/mem_map_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= mem_map_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
RUN_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= ** PASS **

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$($(BUILD_DIR)/V$(TOP) $(RUN_ARGS))"; echo "$$out"; \
	  echo "$$out" | grep -qF -- "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
